// File: hw/gcn_cfg.svh
`ifndef GCN_CFG_SVH
`define GCN_CFG_SVH

// weight bank geometry
`define MAX_NUM_WEIGHT_LAYER 4
`define MAX_FV_NUM 16

// word widths
`define FV_SIZE 8
`define ACC_SIZE 20

// weights handed to the multiplier per beat
`define MULT_PER_PE 4

`endif

// File: hw/gcn_pkg.sv
`include "gcn_cfg.svh"

package gcn_pkg;

    // one weight or feature word
    typedef logic [`FV_SIZE-1:0] weight_t;

    // layer number, 0 .. MAX_NUM_WEIGHT_LAYER-1
    typedef logic [$clog2(`MAX_NUM_WEIGHT_LAYER)-1:0] layer_idx_t;

    // feature index inside one vector
    typedef logic [$clog2(`MAX_FV_NUM)-1:0] fv_idx_t;

    // feature count, one bit wider so MAX_FV_NUM fits
    typedef logic [$clog2(`MAX_FV_NUM):0] fv_count_t;

    // weights of one beat, lane 0 holds the lowest index
    typedef weight_t [`MULT_PER_PE-1:0] weight_slice_t;

    // per-layer dot product
    typedef logic [`ACC_SIZE-1:0] acc_t;

    // start / end of stream flags
    typedef struct packed {
        logic sos;
        logic eos;
    } stream_mark_t;

endpackage

// File: hw/weight_if.sv
`timescale 1ns/100ps

// bank read port, controller side issues, bank answers one cycle later
interface weight_rd_if
    import gcn_pkg::*;
();
    logic          rd_en;
    layer_idx_t    rd_layer;
    // first feature index of the slice
    fv_idx_t       rd_index;
    weight_slice_t rd_data;

    modport ctrl (
        output rd_en,
        output rd_layer,
        output rd_index,
        input  rd_data
    );

    modport bank (
        input  rd_en,
        input  rd_layer,
        input  rd_index,
        output rd_data
    );
endinterface

// weight beats from the controller to the vertex MAC, no back-pressure
interface weight_stream_if
    import gcn_pkg::*;
();
    logic          valid;
    stream_mark_t  mark;
    layer_idx_t    layer;
    // feature index of lane 0
    fv_idx_t       fv_num;
    weight_slice_t data;

    modport src (
        output valid,
        output mark,
        output layer,
        output fv_num,
        output data
    );

    modport dst (
        input valid,
        input mark,
        input layer,
        input fv_num,
        input data
    );
endinterface

// File: hw/weight_bank.sv
`timescale 1ns/100ps
`include "gcn_cfg.svh"

module weight_bank
    import gcn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_en,
    input  layer_idx_t wr_layer,
    input  fv_idx_t    wr_index,
    input  weight_t    wr_data,
    weight_rd_if.bank  rd
);

    // layer by feature storage, contents survive reset
    weight_t mem [`MAX_NUM_WEIGHT_LAYER][`MAX_FV_NUM];

    // lane addresses and words of the slice being read
    fv_idx_t       lane_index [`MULT_PER_PE];
    weight_slice_t rd_slice;

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_layer][wr_index] <= wr_data;
        end
    end

    // consecutive words starting at rd_index
    always_comb begin
        for (int i = 0; i < `MULT_PER_PE; i++) begin
            lane_index[i] = rd.rd_index + fv_idx_t'(i);
        end
    end

    always_comb begin
        for (int i = 0; i < `MULT_PER_PE; i++) begin
            rd_slice[i] = mem[rd.rd_layer][lane_index[i]];
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd.rd_data <= rd_slice;
        end
    end

    // host loads only between runs, so the port never sees both at once
    assert property (@(posedge clk) disable iff (reset)
        !(wr_en && rd.rd_en))
    else $error("weight bank written while a run is reading it");

endmodule

// File: hw/weight_ctrl.sv
`timescale 1ns/100ps
`include "gcn_cfg.svh"

module weight_ctrl
    import gcn_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          fire,
    // number of layers minus one
    input  layer_idx_t    num_weight_layer,
    input  fv_count_t     num_fv,
    output logic          rs_idle,
    weight_rd_if.ctrl     rd,
    weight_stream_if.src  stream
);

    typedef enum logic {
        st_idle,
        st_work
    } state_t;

    state_t       state;
    state_t       nx_state;
    layer_idx_t   cur_layer;
    layer_idx_t   nx_layer;
    fv_count_t    cur_fv;
    fv_count_t    nx_fv;
    fv_count_t    step_fv;
    logic         start;
    logic         layer_done;
    logic         run_done;
    stream_mark_t issue_mark;

    // read stage, lines up layer, index and marks with the bank data
    logic         p1_valid;
    stream_mark_t p1_mark;
    layer_idx_t   p1_layer;
    fv_idx_t      p1_index;

    // fire only counts once the previous run has fully drained
    assign start      = fire && state == st_idle && rs_idle;
    assign step_fv    = cur_fv + fv_count_t'(`MULT_PER_PE);
    assign layer_done = step_fv == num_fv;
    assign run_done   = layer_done && cur_layer == num_weight_layer;

    always_comb begin
        nx_state = state;
        nx_layer = cur_layer;
        nx_fv    = cur_fv;
        case (state)
            st_idle: begin
                if (start) begin
                    nx_state = st_work;
                    nx_layer = '0;
                    nx_fv    = '0;
                end
            end
            st_work: begin
                if (run_done) begin
                    nx_state = st_idle;
                    nx_layer = '0;
                    nx_fv    = '0;
                end else if (layer_done) begin
                    nx_layer = cur_layer + 1'b1;
                    nx_fv    = '0;
                end else begin
                    nx_fv = step_fv;
                end
            end
            default: nx_state = st_idle;
        endcase
    end

    // one slice read per work cycle
    assign rd.rd_en    = state == st_work;
    assign rd.rd_layer = cur_layer;
    assign rd.rd_index = fv_idx_t'(cur_fv);

    // first slice of layer 0 opens the stream, last slice of last layer closes it
    assign issue_mark.sos = rd.rd_en && cur_layer == '0 && cur_fv == '0;
    assign issue_mark.eos = rd.rd_en && run_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            cur_layer    <= '0;
            cur_fv       <= '0;
            rs_idle      <= 1'b1;
            p1_valid     <= 1'b0;
            p1_mark      <= '0;
            stream.valid <= 1'b0;
            stream.mark  <= '0;
        end else begin
            state        <= nx_state;
            cur_layer    <= nx_layer;
            cur_fv       <= nx_fv;
            // stays low until the last read has left the bank
            rs_idle      <= state == st_idle && !p1_valid;
            p1_valid     <= rd.rd_en;
            p1_mark      <= issue_mark;
            stream.valid <= p1_valid;
            stream.mark  <= p1_mark;
        end
    end

    // payload pipeline
    always_ff @(posedge clk) begin
        p1_layer      <= cur_layer;
        p1_index      <= rd.rd_index;
        stream.layer  <= p1_layer;
        stream.fv_num <= p1_index;
        stream.data   <= rd.rd_data;
    end

    // slices must tile the vector exactly
    assert property (@(posedge clk) disable iff (reset)
        start |-> (num_fv != '0 && (num_fv % `MULT_PER_PE) == 0))
    else $error("run started with a feature length that is not a multiple of the beat width");

    assert property (@(posedge clk) disable iff (reset)
        (stream.mark.sos || stream.mark.eos) |-> stream.valid)
    else $error("stream mark raised without a valid beat");

endmodule

// File: hw/vertex_mac.sv
`timescale 1ns/100ps
`include "gcn_cfg.svh"

module vertex_mac
    import gcn_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         feat_wr_en,
    input  fv_idx_t      feat_wr_index,
    input  weight_t      feat_wr_data,
    weight_stream_if.dst stream,
    output logic         out_valid,
    output layer_idx_t   out_layer,
    output acc_t         out_sum
);

    // feature vector of the current vertex
    weight_t feat [`MAX_FV_NUM];

    logic [2*`FV_SIZE-1:0] lane_prod [`MULT_PER_PE];
    acc_t       beat_sum;
    acc_t       acc_base;
    acc_t       acc;
    layer_idx_t acc_layer;
    // acc holds a layer that has not been reported yet
    logic       acc_open;
    // last beat folded into acc carried eos
    logic       eos_seen;
    logic       layer_end;

    always_ff @(posedge clk) begin
        if (reset) begin
            feat <= '{default: '0};
        end else if (feat_wr_en) begin
            feat[feat_wr_index] <= feat_wr_data;
        end
    end

    // lane products against the matching features
    always_comb begin
        fv_idx_t lane_idx;
        for (int i = 0; i < `MULT_PER_PE; i++) begin
            lane_idx     = stream.fv_num + fv_idx_t'(i);
            lane_prod[i] = stream.data[i] * feat[lane_idx];
        end
    end

    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < `MULT_PER_PE; i++) begin
            beat_sum = beat_sum + acc_t'(lane_prod[i]);
        end
    end

    // a beat at feature 0 starts a fresh layer sum
    assign acc_base = (stream.fv_num == '0) ? '0 : acc;

    // layer finished: next beat moved on, or the stream just closed
    assign layer_end = acc_open &&
                       (eos_seen || (stream.valid && stream.layer != acc_layer));

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            acc_layer <= '0;
            acc_open  <= 1'b0;
            eos_seen  <= 1'b0;
        end else if (stream.valid) begin
            acc       <= acc_base + beat_sum;
            acc_layer <= stream.layer;
            acc_open  <= 1'b1;
            eos_seen  <= stream.mark.eos;
        end else if (layer_end) begin
            acc_open  <= 1'b0;
            eos_seen  <= 1'b0;
        end
    end

    assign out_valid = layer_end;
    assign out_layer = acc_layer;
    assign out_sum   = acc;

    assert property (@(posedge clk) disable iff (reset)
        !(feat_wr_en && stream.valid))
    else $error("feature store written during a weight stream");

endmodule

// File: hw/gcn_weight_unit.sv
`timescale 1ns/100ps

module gcn_weight_unit
    import gcn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // host weight load
    input  logic       wt_wr_en,
    input  layer_idx_t wt_wr_layer,
    input  fv_idx_t    wt_wr_index,
    input  weight_t    wt_wr_data,

    // host feature load
    input  logic       feat_wr_en,
    input  fv_idx_t    feat_wr_index,
    input  weight_t    feat_wr_data,

    // run settings and start from the reservation station
    input  layer_idx_t num_weight_layer,
    input  fv_count_t  num_fv,
    input  logic       fire,

    output logic       rs_idle,
    output logic       stream_sos,
    output logic       stream_eos,
    output logic       out_valid,
    output layer_idx_t out_layer,
    output acc_t       out_sum
);

    weight_rd_if     rd_bus ();
    weight_stream_if wt_stream ();

    weight_bank weight_bank_inst (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wt_wr_en),
        .wr_layer (wt_wr_layer),
        .wr_index (wt_wr_index),
        .wr_data  (wt_wr_data),
        .rd       (rd_bus.bank)
    );

    weight_ctrl weight_ctrl_inst (
        .clk              (clk),
        .reset            (reset),
        .fire             (fire),
        .num_weight_layer (num_weight_layer),
        .num_fv           (num_fv),
        .rs_idle          (rs_idle),
        .rd               (rd_bus.ctrl),
        .stream           (wt_stream.src)
    );

    vertex_mac vertex_mac_inst (
        .clk           (clk),
        .reset         (reset),
        .feat_wr_en    (feat_wr_en),
        .feat_wr_index (feat_wr_index),
        .feat_wr_data  (feat_wr_data),
        .stream        (wt_stream.dst),
        .out_valid     (out_valid),
        .out_layer     (out_layer),
        .out_sum       (out_sum)
    );

    // stream flags seen from outside, only on real beats
    assign stream_sos = wt_stream.valid && wt_stream.mark.sos;
    assign stream_eos = wt_stream.valid && wt_stream.mark.eos;

endmodule

// File: test/gcn_weight_unit_tb.sv
`timescale 1ns/100ps
`include "gcn_cfg.svh"

module gcn_weight_unit_tb
    import gcn_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    // long enough to see a wrongly accepted fire start a second stream
    localparam int TAIL_CYCLES = `MAX_NUM_WEIGHT_LAYER * `MAX_FV_NUM / `MULT_PER_PE + 8;

    logic       clk;
    logic       reset;
    logic       wt_wr_en;
    layer_idx_t wt_wr_layer;
    fv_idx_t    wt_wr_index;
    weight_t    wt_wr_data;
    logic       feat_wr_en;
    fv_idx_t    feat_wr_index;
    weight_t    feat_wr_data;
    layer_idx_t num_weight_layer;
    fv_count_t  num_fv;
    logic       fire;
    logic       rs_idle;
    logic       stream_sos;
    logic       stream_eos;
    logic       out_valid;
    layer_idx_t out_layer;
    acc_t       out_sum;

    // contents loaded into the DUT so far
    weight_t model_wt [`MAX_NUM_WEIGHT_LAYER][`MAX_FV_NUM];
    weight_t model_feat [`MAX_FV_NUM];
    // expected sums from the data file, for the next run
    acc_t    file_sum [$];
    int      file_layer [$];
    // observed during one run
    acc_t    got_sum [$];
    int      got_layer [$];
    int      cycle;
    int      sos_count;
    int      eos_count;
    int      sos_cycle;
    int      eos_cycle;
    int      error_count;
    int      timeout_count;
    int      run_count;
    bit      abort;

    gcn_weight_unit gcn_weight_unit_inst (.*);

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic fail_wait(input string what);
        timeout_count++;
        abort = 1'b1;
        $display("timed out waiting for %s", what);
    endtask

    task automatic check_quiet();
        check_value("rs_idle", 1, rs_idle);
        check_value("out_valid", 0, out_valid);
        check_value("stream_sos", 0, stream_sos);
        check_value("stream_eos", 0, stream_eos);
    endtask

    // called on a falling edge, returns on the next one
    task automatic write_weight(input int layer, input int index, input int data);
        wt_wr_en    = 1'b1;
        wt_wr_layer = layer_idx_t'(layer);
        wt_wr_index = fv_idx_t'(index);
        wt_wr_data  = weight_t'(data);
        model_wt[layer][index] = weight_t'(data);
        @(negedge clk);
        wt_wr_en = 1'b0;
    endtask

    task automatic write_feature(input int index, input int data);
        feat_wr_en    = 1'b1;
        feat_wr_index = fv_idx_t'(index);
        feat_wr_data  = weight_t'(data);
        model_feat[index] = weight_t'(data);
        @(negedge clk);
        feat_wr_en = 1'b0;
    endtask

    // next falling edge, then log flags and results
    task automatic step_sample();
        @(negedge clk);
        cycle++;
        if (stream_sos) begin
            sos_count++;
            sos_cycle = cycle;
        end
        if (stream_eos) begin
            eos_count++;
            eos_cycle = cycle;
        end
        if (out_valid) begin
            got_layer.push_back(int'(out_layer));
            got_sum.push_back(out_sum);
        end
    endtask

    function automatic acc_t model_sum(input int layer, input int count);
        acc_t sum;
        sum = '0;
        for (int i = 0; i < count; i++) begin
            sum = sum + acc_t'(model_wt[layer][i]) * acc_t'(model_feat[i]);
        end
        return sum;
    endfunction

    task automatic do_run(input int last_layer, input int fv_len, input int refire);
        int layers;
        int waited;
        layers    = last_layer + 1;
        cycle     = 0;
        sos_count = 0;
        eos_count = 0;
        sos_cycle = 0;
        eos_cycle = 0;
        got_sum.delete();
        got_layer.delete();
        run_count++;
        check_quiet();
        num_weight_layer = layer_idx_t'(last_layer);
        num_fv           = fv_count_t'(fv_len);
        fire             = 1'b1;
        step_sample();
        fire   = 1'b0;
        waited = 0;
        while (rs_idle !== 1'b0 && waited < WAIT_LIMIT) begin
            step_sample();
            waited++;
        end
        if (rs_idle !== 1'b0) begin
            fail_wait("rs_idle to drop after fire");
            return;
        end
        // fire during a busy run, must not start anything
        if (refire != 0) begin
            fire = 1'b1;
            step_sample();
            fire = 1'b0;
        end
        waited = 0;
        while (got_sum.size() < layers && waited < WAIT_LIMIT) begin
            step_sample();
            waited++;
        end
        if (got_sum.size() < layers) begin
            fail_wait("all layer results of the run");
            return;
        end
        waited = 0;
        while (rs_idle !== 1'b1 && waited < WAIT_LIMIT) begin
            step_sample();
            waited++;
        end
        if (rs_idle !== 1'b1) begin
            fail_wait("rs_idle to return high after the run");
            return;
        end
        repeat (TAIL_CYCLES) step_sample();
        check_value("stream_sos count", 1, sos_count);
        check_value("stream_eos count", 1, eos_count);
        check_value("sos not after eos", 1, sos_cycle <= eos_cycle);
        check_value("out_valid count", layers, got_sum.size());
        if (file_sum.size() != 0) begin
            check_value("expected record count", layers, file_sum.size());
        end
        for (int k = 0; k < layers && k < got_sum.size(); k++) begin
            check_value("out_layer", k, got_layer[k]);
            check_value("out_sum", model_sum(k, fv_len), got_sum[k]);
            if (k < file_sum.size()) begin
                check_value("file layer", file_layer[k], k);
                check_value("file sum vs model", file_sum[k], model_sum(k, fv_len));
            end
        end
        file_sum.delete();
        file_layer.delete();
    endtask

    task automatic run_record(input string line);
        byte kind;
        int  a;
        int  b;
        int  c;
        kind = line[0];
        a    = 0;
        b    = 0;
        c    = 0;
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
        case (kind)
            "w": write_weight(a, b, c);
            "f": write_feature(a, b);
            // fill from the full layer and index address
            "p": begin
                for (int l = 0; l < `MAX_NUM_WEIGHT_LAYER; l++) begin
                    for (int i = 0; i < `MAX_FV_NUM; i++) begin
                        write_weight(l, i, l * `MAX_FV_NUM + i + a);
                    end
                end
            end
            "g": begin
                for (int i = 0; i < `MAX_FV_NUM; i++) begin
                    write_feature(i, i + a);
                end
            end
            "x": begin
                for (int i = 0; i < `MAX_FV_NUM; i++) begin
                    write_feature(i, $urandom % 256);
                end
            end
            "e": begin
                file_layer.push_back(a);
                file_sum.push_back(acc_t'(b));
            end
            "r": do_run(a, b, c);
            "#", "\n", "\r": ;
            default: begin
                error_count++;
                $display("unknown record in the stimulus file: %s", line);
            end
        endcase
    endtask

    initial begin
        string line;
        int    fd;
        clk              = 1'b0;
        reset            = 1'b1;
        wt_wr_en         = 1'b0;
        wt_wr_layer      = '0;
        wt_wr_index      = '0;
        wt_wr_data       = '0;
        feat_wr_en       = 1'b0;
        feat_wr_index    = '0;
        feat_wr_data     = '0;
        num_weight_layer = '0;
        num_fv           = '0;
        fire             = 1'b0;
        model_wt         = '{default: '0};
        model_feat       = '{default: '0};
        error_count      = 0;
        timeout_count    = 0;
        run_count        = 0;
        abort            = 1'b0;
        void'($urandom(32'h0c27_db84));
        repeat (16) @(negedge clk);
        reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_quiet();
        end
        fd = $fopen("test/gcn_input.dat", "r");
        if (fd == 0) begin
            error_count++;
            $display("cannot open the stimulus file test/gcn_input.dat");
        end else begin
            while (!abort && $fgets(line, fd) > 0) begin
                run_record(line);
            end
            $fclose(fd);
        end
        if (run_count == 0) begin
            error_count++;
            $display("no run record was executed");
        end
        $display("errors %0d, timeouts %0d, runs %0d", error_count, timeout_count, run_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/gcn_pkg.sv
hw/weight_if.sv
hw/weight_bank.sv
hw/weight_ctrl.sv
hw/vertex_mac.sv
hw/gcn_weight_unit.sv
test/gcn_weight_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the gcn weight unit testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module gcn_weight_unit_tb \
    -f list.f -o gcn_sim &&
    ./obj_dir/gcn_sim > sim.log 2>&1 ||
    echo "build or simulation returned an error"

# show the log, then let its closing message decide
cat sim.log 2>/dev/null
grep -qx "Test completed successfully" sim.log && exit 0 || exit 1

// File: test/gcn_input.dat
# w layer index weight | f index feature | p weight fill base | g feature fill base | x random features
# e layer expected_sum | r layers_minus_one num_fv refire  (all fields hex)
# single layer, one beat
w 0 0 01
w 0 1 02
w 0 2 03
w 0 3 04
f 0 05
f 1 06
f 2 07
f 3 08
e 0 46
r 0 4 0
# full bank, weight = layer*16 + index, feature = index + 1
p 00
g 01
e 0 550
e 1 dd0
e 2 1650
e 3 1ed0
r 3 10 0
# two layers over half the vector, extra fire while busy
e 0 a8
e 1 2e8
r 1 8 1
# rewrite two weights, the rest of the bank must survive
w 1 2 ff
w 2 5 00
e 0 550
e 1 1097
e 2 1572
e 3 1ed0
r 3 10 1
# random features, sums from the testbench model only
x
r 3 10 0
r 2 c 0
